//--- rtl/uart_baud_gen.sv
`include "uart_defs.svh"

module uart_baud_gen (
   input  logic clk,
   input  logic rst_n,
   input  logic restart,
   output logic tick
);

   localparam int cnt_w = $clog2(`UART_BAUD_DIV);
   localparam logic [cnt_w-1:0] cnt_load = cnt_w'(`UART_BAUD_DIV - 1);

   logic [cnt_w-1:0] cnt;
   logic             reload;

   // restart pulls the bit grid onto the new frame
   assign reload = restart || (cnt == '0);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cnt  <= cnt_load;
         tick <= 1'b0;
      end else begin
         if (reload) begin
            cnt <= cnt_load;
         end else begin
            cnt <= cnt - 1'b1;
         end
         tick <= reload;   // first tick lands right after a restart
      end
   end

endmodule

//--- rtl/uart_cmd_ctrl.sv
module uart_cmd_ctrl (
   input  logic        clk,
   input  logic        rst_n,
   input  logic [15:0] cmd_in,
   input  logic        cmd_vld,
   output logic        cmd_rdy,
   output logic [7:0]  read_data,
   output logic        read_rdy,
   output logic        read_err,
   tx_byte_if.ctrl     tx_bus,
   rx_byte_if.ctrl     rx_bus
);

   uart_ctrl_pkg::uart_seq_state_t state;
   uart_ctrl_pkg::uart_seq_state_t state_next;
   uart_ctrl_pkg::uart_byte_sel_t  byte_sel;
   uart_frame_pkg::uart_cmd_u      cmd_q;
   logic                           accept;

   // ============================================================
   // command sequencer
   // ============================================================

   assign cmd_rdy = (state == uart_ctrl_pkg::idle);
   assign accept  = cmd_vld && cmd_rdy;

   always_comb begin
      state_next = state;
      case (state)
         uart_ctrl_pkg::idle:
            if (accept) state_next = uart_ctrl_pkg::send_hi;
         uart_ctrl_pkg::send_hi:
            if (!tx_bus.busy) state_next = uart_ctrl_pkg::wait_hi;
         uart_ctrl_pkg::wait_hi:
            if (tx_bus.done) state_next = uart_ctrl_pkg::send_lo;
         uart_ctrl_pkg::send_lo:
            if (!tx_bus.busy) state_next = uart_ctrl_pkg::wait_lo;
         uart_ctrl_pkg::wait_lo:
            if (tx_bus.done) state_next = uart_ctrl_pkg::idle;
         default:
            state_next = uart_ctrl_pkg::idle;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= uart_ctrl_pkg::idle;
      end else begin
         state <= state_next;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         cmd_q.raw <= cmd_in;
      end
   end

   assign byte_sel = ((state == uart_ctrl_pkg::send_lo) || (state == uart_ctrl_pkg::wait_lo))
                     ? uart_ctrl_pkg::lo : uart_ctrl_pkg::hi;

   assign tx_bus.data  = (byte_sel == uart_ctrl_pkg::hi) ? cmd_q.bytes.hi : cmd_q.bytes.lo;
   assign tx_bus.start = ((state == uart_ctrl_pkg::send_hi) || (state == uart_ctrl_pkg::send_lo))
                         && !tx_bus.busy;

   // ============================================================
   // receive side
   // ============================================================

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         read_rdy <= 1'b0;
         read_err <= 1'b0;
      end else begin
         read_rdy <= rx_bus.valid;
         if (rx_bus.valid) begin
            read_err <= rx_bus.parity_err || rx_bus.stop_err;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rx_bus.valid) begin
         read_data <= rx_bus.data;   // held until the next byte arrives
      end
   end

endmodule

//--- rtl/uart_ctrl_pkg.sv
package uart_ctrl_pkg;

   // command sequencer with one send and one wait state per byte
   typedef enum logic [2:0] {
      idle,
      send_hi,
      wait_hi,
      send_lo,
      wait_lo
   } uart_seq_state_t;

   // which half of the command word is on the transmit side
   typedef enum logic {
      hi,
      lo
   } uart_byte_sel_t;

endpackage

//--- rtl/uart_defs.svh
`ifndef UART_DEFS_SVH
`define UART_DEFS_SVH

// clock cycles per serial bit which must be even and at least 4
`define UART_BAUD_DIV 8

`define UART_FRAME_BITS 11   // start, 8 data, parity and stop

`define UART_SYNC_STAGES 2   // flops between the rx pin and the receiver

`endif

//--- rtl/uart_frame_pkg.sv
package uart_frame_pkg;

   // ============================================================
   // serial frame
   // ============================================================

   typedef logic [7:0] uart_byte_t;

   // bit 0 leaves the wire first, so the start bit sits at the bottom
   typedef struct packed {
      logic       stop;
      logic       parity;   // odd over data plus this bit
      uart_byte_t data;
      logic       start;
   } uart_frame_t;

   // ============================================================
   // command word
   // ============================================================

   typedef struct packed {
      uart_byte_t hi;   // goes out first
      uart_byte_t lo;
   } uart_cmd_bytes_t;

   typedef union packed {
      logic [15:0]     raw;
      uart_cmd_bytes_t bytes;
   } uart_cmd_u;

endpackage

//--- rtl/uart_if.sv
// ============================================================
// control to transmitter
// ============================================================

interface tx_byte_if;

   uart_frame_pkg::uart_byte_t data;
   logic                       start;   // only pulsed while busy is low
   logic                       busy;
   logic                       done;    // last cycle of the stop bit

   modport ctrl (
      output data,
      output start,
      input  busy,
      input  done
   );

   modport tx (
      input  data,
      input  start,
      output busy,
      output done
   );

endinterface

// ============================================================
// receiver to control
// ============================================================

interface rx_byte_if;

   uart_frame_pkg::uart_byte_t data;
   logic                       valid;        // data and flags hold only in this cycle
   logic                       parity_err;
   logic                       stop_err;

   modport rx (
      output data,
      output valid,
      output parity_err,
      output stop_err
   );

   modport ctrl (
      input data,
      input valid,
      input parity_err,
      input stop_err
   );

endinterface

//--- rtl/uart_rx_frame.sv
`include "uart_defs.svh"

module uart_rx_frame (
   input  logic  clk,
   input  logic  rst_n,
   input  logic  rx,
   rx_byte_if.rx rx_bus
);

   localparam int cnt_w = $clog2(`UART_BAUD_DIV);
   localparam logic [cnt_w-1:0] bit_load  = cnt_w'(`UART_BAUD_DIV - 1);
   localparam logic [cnt_w-1:0] half_load = cnt_w'(`UART_BAUD_DIV / 2 - 1);
   localparam int idx_w = $clog2(`UART_FRAME_BITS);
   localparam logic [idx_w-1:0] stop_idx = idx_w'(`UART_FRAME_BITS - 1);

   logic [`UART_SYNC_STAGES-1:0] sync_q;
   logic                         rx_s;
   logic                         rx_d;
   logic                         fall;
   logic                         active;
   logic [cnt_w-1:0]             cnt;
   logic [idx_w-1:0]             bit_idx;
   logic                         sample;
   uart_frame_pkg::uart_frame_t  frame_q;

   // ============================================================
   // line synchronizer and edge detect
   // ============================================================

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sync_q <= '1;   // idle line is high
         rx_d   <= 1'b1;
      end else begin
         sync_q <= {sync_q[`UART_SYNC_STAGES-2:0], rx};
         rx_d   <= rx_s;
      end
   end

   assign rx_s   = sync_q[`UART_SYNC_STAGES-1];
   assign fall   = rx_d && !rx_s;
   assign sample = active && (cnt == '0);   // middle of the current bit

   // ============================================================
   // bit timing
   // ============================================================

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         active       <= 1'b0;
         cnt          <= '0;
         bit_idx      <= '0;
         rx_bus.valid <= 1'b0;
      end else begin
         rx_bus.valid <= 1'b0;
         if (!active) begin
            if (fall) begin
               active  <= 1'b1;
               cnt     <= half_load;   // first sample is half a bit in
               bit_idx <= '0;
            end
         end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
         end else if ((bit_idx == '0) && rx_s) begin
            active <= 1'b0;   // start bit did not hold so it was only a glitch
         end else if (bit_idx == stop_idx) begin
            active       <= 1'b0;
            rx_bus.valid <= 1'b1;
         end else begin
            cnt     <= bit_load;
            bit_idx <= bit_idx + 1'b1;
         end
      end
   end

   // bits come in LSB first and settle into place after the stop sample
   always_ff @(posedge clk) begin
      if (sample) begin
         frame_q <= uart_frame_pkg::uart_frame_t'({rx_s, frame_q[`UART_FRAME_BITS-1:1]});
      end
   end

   assign rx_bus.data       = frame_q.data;
   assign rx_bus.parity_err = ~^{frame_q.data, frame_q.parity};   // even count of ones
   assign rx_bus.stop_err   = ~frame_q.stop;

endmodule

//--- rtl/uart_top.sv
module uart_top (
   input  logic        clk,
   input  logic        rst_n,
   input  logic [15:0] cmd_in,
   input  logic        cmd_vld,
   input  logic        rx,
   output logic        tx,
   output logic        cmd_rdy,
   output logic [7:0]  read_data,
   output logic        read_rdy,
   output logic        read_err
);

   logic tick;
   logic restart;

   tx_byte_if tx_bus ();
   rx_byte_if rx_bus ();

   uart_cmd_ctrl uart_cmd_ctrl_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .cmd_in    (cmd_in),
      .cmd_vld   (cmd_vld),
      .cmd_rdy   (cmd_rdy),
      .read_data (read_data),
      .read_rdy  (read_rdy),
      .read_err  (read_err),
      .tx_bus    (tx_bus.ctrl),
      .rx_bus    (rx_bus.ctrl)
   );

   uart_baud_gen uart_baud_gen_inst (
      .clk     (clk),
      .rst_n   (rst_n),
      .restart (restart),
      .tick    (tick)
   );

   uart_tx_frame uart_tx_frame_inst (
      .clk     (clk),
      .rst_n   (rst_n),
      .tx_bus  (tx_bus.tx),
      .tick    (tick),
      .restart (restart),
      .tx      (tx)
   );

   // receiver keeps its own timing locked to the incoming start edge
   uart_rx_frame uart_rx_frame_inst (
      .clk    (clk),
      .rst_n  (rst_n),
      .rx     (rx),
      .rx_bus (rx_bus.rx)
   );

endmodule

//--- rtl/uart_tx_frame.sv
`include "uart_defs.svh"

module uart_tx_frame (
   input  logic  clk,
   input  logic  rst_n,
   tx_byte_if.tx tx_bus,
   input  logic  tick,
   output logic  restart,
   output logic  tx
);

   localparam int bit_w = $clog2(`UART_FRAME_BITS + 1);
   localparam logic [bit_w-1:0] last_bit = bit_w'(`UART_FRAME_BITS);

   uart_frame_pkg::uart_frame_t frame_next;
   uart_frame_pkg::uart_frame_t shreg;
   logic [bit_w-1:0]            bit_cnt;
   logic                        load;
   logic                        shift;

   // ============================================================
   // frame assembly
   // ============================================================

   always_comb begin
      frame_next.start  = 1'b0;
      frame_next.data   = tx_bus.data;
      frame_next.parity = ~^tx_bus.data;   // makes the count of ones odd
      frame_next.stop   = 1'b1;
   end

   assign load    = tx_bus.start && !tx_bus.busy;
   assign shift   = tx_bus.busy && tick;
   assign restart = load;

   // all bits are out and the stop bit has had its full period
   assign tx_bus.done = shift && (bit_cnt == last_bit);

   // ============================================================
   // shifter
   // ============================================================

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         tx_bus.busy <= 1'b0;
         bit_cnt     <= '0;
         tx          <= 1'b1;
      end else if (load) begin
         tx_bus.busy <= 1'b1;
         bit_cnt     <= '0;
      end else if (shift) begin
         if (bit_cnt == last_bit) begin
            tx_bus.busy <= 1'b0;   // line is left high after the stop bit
         end else begin
            tx      <= shreg[0];
            bit_cnt <= bit_cnt + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         shreg <= frame_next;
      end else if (shift) begin
         shreg <= uart_frame_pkg::uart_frame_t'({1'b1, shreg[`UART_FRAME_BITS-1:1]});
      end
   end

endmodule

//--- tests/tb_clk_gen.sv
module tb_clk_gen (
   output logic clk,
   output logic rst_n
);
   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;   // 8 ns period
   end

   initial begin
      rst_n = 1'b0;
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;   // released away from the active edge
   end

endmodule

//--- tests/uart_tb.sv
`include "uart_defs.svh"

module uart_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int baud = `UART_BAUD_DIV;
   localparam int max_cycles = 40 * (22 * `UART_BAUD_DIV + 16) + 2000;

   logic        clk;
   logic        rst_n;
   logic [15:0] cmd_in;
   logic        cmd_vld;
   logic        rx;
   logic        tx;
   logic        cmd_rdy;
   logic [7:0]  read_data;
   logic        read_rdy;
   logic        read_err;
   logic        loopback;
   logic        drv_rx;

   uart_frame_pkg::uart_frame_t   got_frame_q[$];
   uart_frame_pkg::uart_frame_t   exp_frame_q[$];
   uart_ctrl_pkg::uart_byte_sel_t exp_sel_q[$];
   logic [8:0]                    exp_read_q[$];   // {read_err, read_data}
   uart_frame_pkg::uart_frame_t   got_f;
   uart_frame_pkg::uart_frame_t   exp_f;
   uart_ctrl_pkg::uart_byte_sel_t exp_s;
   logic [8:0]                    exp_r;
   int          err_cnt = 0;
   int          test_cnt = 0;
   int          test_fail = 0;
   int          test_err_start = 0;
   int          frames_seen = 0;
   int          read_cnt = 0;

   assign rx = loopback ? tx : drv_rx;

   tb_clk_gen tb_clk_gen_inst (.clk(clk), .rst_n(rst_n));

   uart_top uart_top_inst (
      .clk(clk), .rst_n(rst_n), .cmd_in(cmd_in), .cmd_vld(cmd_vld), .rx(rx),
      .tx(tx), .cmd_rdy(cmd_rdy), .read_data(read_data), .read_rdy(read_rdy),
      .read_err(read_err)
   );

   // ============================================================
   // reference model and helpers
   // ============================================================

   function automatic uart_frame_pkg::uart_frame_t ref_frame(input uart_frame_pkg::uart_byte_t b);
      uart_frame_pkg::uart_frame_t f;
      int ones;
      ones = 0;
      for (int i = 0; i < 8; i++) ones += b[i];
      f.start  = 1'b0;
      f.data   = b;
      f.parity = (ones % 2 == 0);   // brings the total to an odd count
      f.stop   = 1'b1;
      return f;
   endfunction

   function automatic logic expected_err(input uart_frame_pkg::uart_frame_t f);
      int ones;
      ones = f.parity;
      for (int i = 0; i < 8; i++) ones += f.data[i];
      return (ones % 2 == 0) || !f.stop;
   endfunction

   task automatic log_error(input string msg);
      $display("%s", msg);
      err_cnt++;
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      assert (got === exp) else log_error($sformatf("ERROR %s: got %h expected %h", name, got, exp));
   endtask

   task automatic end_test(input string name);
      test_cnt++;
      if (err_cnt != test_err_start) begin
         test_fail++;
         $display("test %0d %s: failed", test_cnt, name);
      end else begin
         $display("test %0d %s: passed", test_cnt, name);
      end
      test_err_start = err_cnt;
   endtask

   task automatic wait_quiet();
      while (exp_frame_q.size() != 0 || exp_read_q.size() != 0 || cmd_rdy !== 1'b1)
         @(negedge clk);
      repeat (2 * baud) @(negedge clk);   // room for any stray frame or pulse to show up
   endtask

   task automatic send_cmd(input logic [15:0] value, input bit stray);
      uart_frame_pkg::uart_cmd_u cmd;
      int n;
      int start_frames;
      cmd.raw = value;
      while (cmd_rdy !== 1'b1) @(negedge clk);
      exp_frame_q.push_back(ref_frame(cmd.bytes.hi));
      exp_sel_q.push_back(uart_ctrl_pkg::hi);
      exp_frame_q.push_back(ref_frame(cmd.bytes.lo));
      exp_sel_q.push_back(uart_ctrl_pkg::lo);
      if (loopback) begin
         exp_read_q.push_back({1'b0, cmd.bytes.hi});
         exp_read_q.push_back({1'b0, cmd.bytes.lo});
      end
      start_frames = frames_seen;
      cmd_in  = cmd.raw;
      cmd_vld = 1'b1;
      @(negedge clk);
      cmd_vld = 1'b0;
      cmd_in  = 16'($urandom);   // the word must already be held inside
      check_bit("cmd_rdy", cmd_rdy, 1'b0);
      @(negedge clk);
      check_bit("tx", tx, 1'b1);
      @(negedge clk);
      check_bit("tx", tx, 1'b0);   // start bit two cycles after the accept edge
      n = 0;
      while (cmd_rdy !== 1'b1) begin
         @(negedge clk);
         n++;
         if (stray && n == 40) begin
            cmd_vld = 1'b1;
            cmd_in  = 16'($urandom);
         end
         if (stray && n == 41) cmd_vld = 1'b0;
      end
      assert (frames_seen == start_frames + 2)
         else log_error("cmd_rdy rose before both frames of the command were on the line");
   endtask

   task automatic drive_serial_frame(input uart_frame_pkg::uart_frame_t f);
      exp_read_q.push_back({expected_err(f), f.data});
      for (int i = 0; i < `UART_FRAME_BITS; i++) begin
         drv_rx = f[i];
         repeat (baud) @(negedge clk);
      end
      drv_rx = 1'b1;
      repeat (2 * baud) @(negedge clk);
   endtask

   // ============================================================
   // serial monitor and compare
   // ============================================================

   initial begin
      logic samp [baud];
      uart_frame_pkg::uart_frame_t bits;
      wait (rst_n === 1'b1);
      forever begin
         @(negedge tx);
         for (int i = 0; i < `UART_FRAME_BITS; i++) begin
            for (int k = 0; k < baud; k++) begin
               @(negedge clk);
               samp[k] = tx;
            end
            for (int k = 1; k < baud; k++)
               assert (samp[k] === samp[0])
                  else log_error($sformatf("tx bit %0d did not hold for a full bit period", i));
            bits[i] = samp[baud / 2];   // middle of the bit
         end
         got_frame_q.push_back(bits);
         frames_seen++;
      end
   end

   always @(negedge clk) begin
      if (got_frame_q.size() != 0) begin
         got_f = got_frame_q.pop_front();
         assert (exp_frame_q.size() != 0) else log_error("tx sent a frame that no test expected");
         if (exp_frame_q.size() != 0) begin
            exp_f = exp_frame_q.pop_front();
            exp_s = exp_sel_q.pop_front();
            assert (got_f == exp_f) else log_error($sformatf(
               "ERROR tx frame (%s byte): got %h expected %h", exp_s.name(), got_f, exp_f));
         end
      end
      if (read_rdy === 1'b1) begin
         read_cnt++;
         assert (exp_read_q.size() != 0) else log_error("read_rdy pulsed with no byte expected");
         if (exp_read_q.size() != 0) begin
            exp_r = exp_read_q.pop_front();
            assert (read_data === exp_r[7:0]) else log_error($sformatf(
               "ERROR read_data: got %h expected %h", read_data, exp_r[7:0]));
            check_bit("read_err", read_err, exp_r[8]);
         end
      end
   end

   // ============================================================
   // tests
   // ============================================================

   initial begin
      uart_frame_pkg::uart_frame_t f;
      int reads_before;
      void'($urandom(32'h4c82));
      cmd_in   = '0;
      cmd_vld  = 1'b0;
      drv_rx   = 1'b1;
      loopback = 1'b0;
      wait (rst_n === 1'b1);
      @(negedge clk);

      check_bit("tx", tx, 1'b1);
      check_bit("cmd_rdy", cmd_rdy, 1'b1);
      check_bit("read_rdy", read_rdy, 1'b0);
      check_bit("read_err", read_err, 1'b0);
      repeat (4 * baud) begin
         @(negedge clk);
         check_bit("tx", tx, 1'b1);
      end
      end_test("reset values and idle line");

      repeat (20) send_cmd(16'($urandom), 1'b0);
      wait_quiet();
      end_test("random commands on tx");

      send_cmd(16'($urandom), 1'b1);
      wait_quiet();
      send_cmd(16'($urandom), 1'b0);
      wait_quiet();
      end_test("cmd_vld ignored while busy");

      loopback = 1'b1;
      repeat (3) send_cmd(16'($urandom), 1'b0);
      wait_quiet();
      loopback = 1'b0;
      repeat (2 * baud) @(negedge clk);
      end_test("loopback receive");

      f = ref_frame(8'($urandom));
      f.parity = ~f.parity;
      drive_serial_frame(f);
      f = ref_frame(8'($urandom));
      f.stop = 1'b0;
      drive_serial_frame(f);
      drive_serial_frame(ref_frame(8'($urandom)));   // clean frame clears read_err
      wait_quiet();
      check_bit("read_err", read_err, 1'b0);
      end_test("parity and stop errors");

      reads_before = read_cnt;
      drv_rx = 1'b0;
      repeat (baud / 2 - 1) @(negedge clk);
      drv_rx = 1'b1;
      repeat (12 * baud) @(negedge clk);
      assert (read_cnt == reads_before) else log_error("a short low glitch on rx produced read_rdy");
      end_test("rx glitch rejected");

      $display("tests %0d, failed %0d, failed checks %0d", test_cnt, test_fail, err_cnt);
      if (err_cnt == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

   initial begin
      int cycles;
      cycles = 0;
      while (cycles < max_cycles) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout: the run did not finish within %0d cycles", max_cycles);
      $display("ERRORS FOUND");
      $finish;
   end

endmodule

//--- uart_top.f
+incdir+rtl
rtl/uart_frame_pkg.sv
rtl/uart_ctrl_pkg.sv
rtl/uart_if.sv
rtl/uart_baud_gen.sv
rtl/uart_tx_frame.sv
rtl/uart_rx_frame.sv
rtl/uart_cmd_ctrl.sv
rtl/uart_top.sv
tests/tb_clk_gen.sv
tests/uart_tb.sv
